/* Makefile */
# Verilator build and run of the pcie_cont_write testbench
VERILATOR ?= verilator
TOP       ?= tb_pcie_cont_write
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard src/*.sv src/*.svh dv/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_pcie_cont_write.sv */
// Directed checks that start from reset with all slots free; each wait gives up after 200 cycles
`timescale 1ns/1ps
`include "cont_write_macros.svh"

module tb_pcie_cont_write
  import host_core_pkg::*, pcie_dma_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic                  pcie_clk;
  logic                  pcie_rst;
  pcie_addr_t            host_desc_pcie_addr;
  host_ram_addr_t        host_desc_ram_addr;
  dma_len_t              host_desc_len;
  host_tag_t             host_desc_tag;
  logic                  host_desc_valid;
  logic                  host_desc_ready;
  ctrl_word_t            host_core_ctrl_data;
  core_id_t              host_core_ctrl_dest;
  logic                  host_core_ctrl_valid;
  logic                  host_core_ctrl_ready;
  host_tag_t             host_status_tag;
  logic                  host_status_valid;
  logic [`CW_DATA_W-1:0] core_tx_data;
  logic [`CW_KEEP_W-1:0] core_tx_keep;
  core_user_t            core_tx_user;
  logic                  core_tx_valid;
  logic                  core_tx_last;
  logic                  core_tx_ready;
  pcie_addr_t            pcie_desc_pcie_addr;
  ram_addr_t             pcie_desc_ram_addr;
  dma_len_t              pcie_desc_len;
  slot_t                 pcie_desc_tag;
  logic                  pcie_desc_valid;
  logic                  pcie_desc_ready;
  slot_t                 pcie_status_tag;
  logic                  pcie_status_valid;
  ram_word_t             ram_rd_addr;
  logic                  ram_rd_en;
  logic [`CW_DATA_W-1:0] ram_rd_data;
  logic                  ram_rd_data_valid;

  int errors;
  int checks;
  int tests;
  logic [15:0] lfsr;

  // Slot model: the sink holds the lowest free slot whenever it is idle
  logic [`CW_SLOT_COUNT-1:0] free_model;
  logic                      have_slot;
  slot_t                     held_slot;
  logic [`CW_DATA_W-1:0]     slot_data [`CW_SLOT_COUNT][64];
  logic [`CW_KEEP_W-1:0]     slot_keep [`CW_SLOT_COUNT][64];
  int                        slot_words [`CW_SLOT_COUNT];

  pcie_addr_t exp_addr_q [$];
  dma_len_t   exp_len_q [$];
  slot_t      exp_slot_q [$];

  pcie_cont_write pcie_cont_write_inst (.*);

  initial begin
    pcie_clk = 1'b0;
    forever #4 pcie_clk = ~pcie_clk;
  end

  task automatic report_failure(input string why);
    errors++;
    $display("%s", why);
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_ctrl(input ctrl_word_t got, input core_id_t got_dest,
                            input ctrl_word_t exp, input core_id_t exp_dest);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR host_core_ctrl_data got 0x%h expected 0x%h", got, exp);
    end
    if (got_dest !== exp_dest) begin
      errors++;
      $display("ERROR host_core_ctrl_dest got 0x%h expected 0x%h", got_dest, exp_dest);
    end
  endtask

  task automatic check_tag(input host_tag_t got, input host_tag_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR host_status_tag got 0x%h expected 0x%h", got, exp);
    end
  endtask

  task automatic check_desc(input pcie_addr_t addr, input ram_addr_t ram, input dma_len_t len,
                            input slot_t tag, input pcie_addr_t e_addr, input ram_addr_t e_ram,
                            input dma_len_t e_len, input slot_t e_tag);
    checks++;
    if (addr !== e_addr) begin
      errors++;
      $display("ERROR pcie_desc_pcie_addr got 0x%h expected 0x%h", addr, e_addr);
    end
    if (ram !== e_ram) begin
      errors++;
      $display("ERROR pcie_desc_ram_addr got 0x%h expected 0x%h", ram, e_ram);
    end
    if (len !== e_len) begin
      errors++;
      $display("ERROR pcie_desc_len got 0x%h expected 0x%h", len, e_len);
    end
    if (tag !== e_tag) begin
      errors++;
      $display("ERROR pcie_desc_tag got 0x%h expected 0x%h", tag, e_tag);
    end
  endtask

  // Lanes without a byte enable were never written
  task automatic check_ram(input logic [`CW_DATA_W-1:0] got, input logic [`CW_DATA_W-1:0] exp,
                           input logic [`CW_KEEP_W-1:0] be);
    logic [`CW_DATA_W-1:0] mask;
    checks++;
    for (int i = 0; i < `CW_KEEP_W; i++)
      mask[8*i +: 8] = {8{be[i]}};
    if ((got & mask) !== (exp & mask)) begin
      errors++;
      $display("ERROR ram_rd_data got 0x%h expected 0x%h", got & mask, exp & mask);
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output logic [`CW_DATA_W-1:0] w);
    w = '0;
    for (int i = 0; i < `CW_DATA_W; i++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[`CW_DATA_W-2:0], lfsr[0]};
    end
  endtask

  function automatic dma_len_t count_keep(input logic [`CW_KEEP_W-1:0] keep);
    return dma_len_t'($countones(keep));
  endfunction

  task automatic take_lowest_free();
    for (int i = 0; i < `CW_SLOT_COUNT; i++)
      if (!have_slot && free_model[i]) begin
        held_slot     = slot_t'(i);
        have_slot     = 1'b1;
        free_model[i] = 1'b0;
      end
  endtask

  task automatic host_request(input pcie_addr_t addr, input host_ram_addr_t ram,
                              input dma_len_t len, input host_tag_t tag);
    ctrl_word_t exp;
    int t;
    exp = '0;
    exp[127:64] = addr;
    exp[47:32]  = ram[15:0];
    exp[15:0]   = len;
    t = 0;
    @(negedge pcie_clk);
    host_desc_pcie_addr = addr;
    host_desc_ram_addr  = ram;
    host_desc_len       = len;
    host_desc_tag       = tag;
    host_desc_valid     = 1'b1;
    // Control pulse follows the accepting edge by one cycle
    while (!host_core_ctrl_valid && t < TIMEOUT) begin
      @(negedge pcie_clk);
      t++;
    end
    host_desc_valid = 1'b0;
    if (!host_core_ctrl_valid)
      report_failure("host request was never accepted");
    else
      check_ctrl(host_core_ctrl_data, host_core_ctrl_dest, exp, ram[17:16]);
  endtask

  task automatic drive_beat(input logic [`CW_DATA_W-1:0] data, input logic [`CW_KEEP_W-1:0] keep,
                            input core_user_t user, input logic last);
    int t;
    t = 0;
    @(negedge pcie_clk);
    core_tx_data  = data;
    core_tx_keep  = keep;
    core_tx_user  = user;
    core_tx_last  = last;
    core_tx_valid = 1'b1;
    while (!core_tx_ready && t < TIMEOUT) begin
      @(negedge pcie_clk);
      t++;
    end
    if (!core_tx_ready)
      report_failure("frame beat was never taken, core_tx_ready stayed low");
  endtask

  task automatic send_frame(input pcie_addr_t addr, input core_user_t user, input int n,
                            input logic [`CW_KEEP_W-1:0] last_keep);
    logic [`CW_DATA_W-1:0] w;
    slot_t s;
    dma_len_t len;
    len = '0;
    drive_beat(addr, '1, user, n == 0);
    if (!have_slot)
      report_failure("frame accepted while every slot is in use");
    s = held_slot;
    for (int i = 0; i < n; i++) begin
      rand_word(w);
      slot_data[s][i] = w;
      slot_keep[s][i] = (i == n - 1) ? last_keep : '1;
      len = len + count_keep(slot_keep[s][i]);
      drive_beat(w, slot_keep[s][i], user, i == n - 1);
    end
    @(negedge pcie_clk);
    core_tx_valid = 1'b0;
    core_tx_last  = 1'b0;
    slot_words[s] = n;
    exp_addr_q.push_back(addr);
    exp_len_q.push_back(len);
    exp_slot_q.push_back(s);
    have_slot = 1'b0;
    take_lowest_free();
  endtask

  task automatic pop_desc();
    int t;
    t = 0;
    while (!pcie_desc_valid && t < TIMEOUT) begin
      @(negedge pcie_clk);
      t++;
    end
    if (!pcie_desc_valid)
      report_failure("no descriptor appeared on pcie_desc_valid");
    else if (exp_slot_q.size() == 0)
      report_failure("descriptor appeared with no frame outstanding");
    else begin
      check_desc(pcie_desc_pcie_addr, pcie_desc_ram_addr, pcie_desc_len, pcie_desc_tag,
                 exp_addr_q[0], ram_addr_t'(int'(exp_slot_q[0]) * `CW_SLOT_BYTES),
                 exp_len_q[0], exp_slot_q[0]);
      void'(exp_addr_q.pop_front());
      void'(exp_len_q.pop_front());
      void'(exp_slot_q.pop_front());
      pcie_desc_ready = 1'b1;
      @(negedge pcie_clk);
      pcie_desc_ready = 1'b0;
    end
  endtask

  task automatic complete_slot(input slot_t s);
    @(negedge pcie_clk);
    pcie_status_tag   = s;
    pcie_status_valid = 1'b1;
    @(negedge pcie_clk);
    pcie_status_valid = 1'b0;
    free_model[s] = 1'b1;
    if (!have_slot)
      take_lowest_free();
  endtask

  task automatic wait_status(input host_tag_t exp);
    int t;
    t = 0;
    while (!host_status_valid && t < TIMEOUT) begin
      @(negedge pcie_clk);
      t++;
    end
    if (!host_status_valid)
      report_failure("host status never returned after a frame tag zero completion");
    else
      check_tag(host_status_tag, exp);
  endtask

  task automatic read_slot(input slot_t s);
    for (int i = 0; i < slot_words[s]; i++) begin
      @(negedge pcie_clk);
      check_flag("ram_rd_data_valid", ram_rd_data_valid, 1'b0);
      ram_rd_addr = ram_word_t'(int'(s) * (`CW_SLOT_BYTES / 8) + i);
      ram_rd_en   = 1'b1;
      @(negedge pcie_clk);
      ram_rd_en = 1'b0;
      check_flag("ram_rd_data_valid", ram_rd_data_valid, 1'b1);
      check_ram(ram_rd_data, slot_data[s][i], slot_keep[s][i]);
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    if (errors == err_before)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, errors - err_before);
  endtask

  task automatic test_request_forwarding();
    int e;
    e = errors;
    check_flag("host_core_ctrl_valid", host_core_ctrl_valid, 1'b0);
    check_flag("host_status_valid", host_status_valid, 1'b0);
    check_flag("pcie_desc_valid", pcie_desc_valid, 1'b0);
    host_request(64'h0000_0040_1234_5000, 32'h0001_0a00, 16'd40, 32'hc0de_0001);
    // Core 1 holds a tag now, so this one must stall
    @(negedge pcie_clk);
    host_desc_ram_addr = 32'h0001_0b00;
    host_desc_tag      = 32'hc0de_0002;
    host_desc_valid    = 1'b1;
    repeat (8) begin
      @(negedge pcie_clk);
      check_flag("host_desc_ready", host_desc_ready, 1'b0);
      check_flag("host_core_ctrl_valid", host_core_ctrl_valid, 1'b0);
    end
    host_desc_valid = 1'b0;
    host_request(64'h0000_0040_9abc_0000, 32'h0002_0100, 16'd1024, 32'hc0de_0003);
    finish_test("request_forwarding", e);
  endtask

  task automatic test_frame_to_descriptor();
    int e;
    e = errors;
    send_frame(64'h0000_0040_1234_5000, core_user_t'({2'd1, 6'h05}), 5, 8'h0f);
    pop_desc();
    send_frame(64'h0000_0040_1234_5800, core_user_t'({2'd1, 6'h00}), 3, 8'hff);
    pop_desc();
    finish_test("frame_to_descriptor", e);
  endtask

  task automatic test_scratchpad_readback();
    int e;
    e = errors;
    read_slot(2'd0);
    read_slot(2'd1);
    finish_test("scratchpad_readback", e);
  endtask

  task automatic test_completion();
    int e;
    e = errors;
    complete_slot(2'd0);
    repeat (10) begin
      @(negedge pcie_clk);
      check_flag("host_status_valid", host_status_valid, 1'b0);
    end
    host_desc_ram_addr = 32'h0001_0000;
    @(negedge pcie_clk);
    check_flag("host_desc_ready", host_desc_ready, 1'b0);
    complete_slot(2'd1);
    wait_status(32'hc0de_0001);
    host_request(64'h0000_0040_5555_0000, 32'h0001_0c00, 16'd64, 32'hc0de_0004);
    finish_test("completion", e);
  endtask

  task automatic test_slot_exhaustion();
    int e;
    e = errors;
    // Descriptors pile up in the FIFO while ready is low
    for (int i = 0; i < `CW_SLOT_COUNT; i++)
      send_frame(64'h0000_0041_0000_0000 + 64'(i * 'h1000), core_user_t'(8'h91 + 8'(i)),
                 2 + i, 8'h3f);
    for (int i = 0; i < `CW_SLOT_COUNT; i++)
      pop_desc();
    fork
      send_frame(64'h0000_0042_0000_0000, core_user_t'(8'h9a), 4, 8'h01);
      begin
        repeat (10) begin
          @(negedge pcie_clk);
          check_flag("core_tx_ready", core_tx_ready, 1'b0);
        end
        complete_slot(2'd1);
      end
    join
    pop_desc();
    finish_test("slot_exhaustion", e);
  endtask

  initial begin
    pcie_rst             = 1'b1;
    host_desc_pcie_addr  = '0;
    host_desc_ram_addr   = '0;
    host_desc_len        = '0;
    host_desc_tag        = '0;
    host_desc_valid      = 1'b0;
    host_core_ctrl_ready = 1'b1;
    core_tx_data         = '0;
    core_tx_keep         = '0;
    core_tx_user         = '0;
    core_tx_valid        = 1'b0;
    core_tx_last         = 1'b0;
    pcie_desc_ready      = 1'b0;
    pcie_status_tag      = '0;
    pcie_status_valid    = 1'b0;
    ram_rd_addr          = '0;
    ram_rd_en            = 1'b0;
    errors               = 0;
    checks               = 0;
    tests                = 0;
    lfsr                 = 16'd62042;
    free_model           = '1;
    have_slot            = 1'b0;
    take_lowest_free();
    repeat (16) @(negedge pcie_clk);
    pcie_rst = 1'b0;
    test_request_forwarding();
    test_frame_to_descriptor();
    test_scratchpad_readback();
    test_completion();
    test_slot_exhaustion();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* src/cont_write_macros.svh */
// Sizes fixed at compile time; slot count must be a power of two and at most the FIFO depth
`ifndef CONT_WRITE_MACROS_SVH
`define CONT_WRITE_MACROS_SVH

// Cores and their address window
`define CW_CORE_COUNT      4
`define CW_CORE_ID_W       2
`define CW_CORE_ADDR_W     16

// Scratchpad slots, 2 KiB each
`define CW_SLOT_COUNT      4
`define CW_SLOT_W          2
`define CW_SLOT_BYTES      2048
`define CW_SLOT_BYTES_LOG2 11

`define CW_DATA_W          64
`define CW_KEEP_W          8
// Core id in the top bits, frame tag below
`define CW_USER_W          8

`define CW_PCIE_ADDR_W     64
`define CW_HOST_RAM_ADDR_W 32
`define CW_LEN_W           16
`define CW_HOST_TAG_W      32
`define CW_RAM_ADDR_W      13
`define CW_RAM_WORD_W      10

`endif

/* src/desc_fifo.sv */
// Holds up to slot count plus one descriptors; writer must never push when full
`timescale 1ns/1ps
`include "cont_write_macros.svh"

module desc_fifo
  import pcie_dma_pkg::*;
(
  input  logic       pcie_clk,
  input  logic       pcie_rst,

  input  logic       in_valid,
  input  pcie_addr_t in_pcie_addr,
  input  ram_addr_t  in_ram_addr,
  input  dma_len_t   in_len,
  input  slot_t      in_tag,

  output logic       out_valid,
  output pcie_addr_t out_pcie_addr,
  output ram_addr_t  out_ram_addr,
  output dma_len_t   out_len,
  output slot_t      out_tag,
  input  logic       out_ready
);

  localparam int PTR_W = $clog2(`CW_SLOT_COUNT);

  typedef struct packed {
    pcie_addr_t pcie_addr;
    ram_addr_t  ram_addr;
    dma_len_t   len;
    slot_t      tag;
  } entry_t;

  entry_t           mem [`CW_SLOT_COUNT];
  entry_t           in_entry;
  entry_t           out_q;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             load;
  logic             rd;
  logic             wr;

  assign in_entry = '{in_pcie_addr, in_ram_addr, in_len, in_tag};
  assign load     = !out_valid || out_ready;
  assign rd       = load && (count != '0);
  // Empty buffer passes straight to the output register
  assign wr       = in_valid && !(load && (count == '0));

  assign out_pcie_addr = out_q.pcie_addr;
  assign out_ram_addr  = out_q.ram_addr;
  assign out_len       = out_q.len;
  assign out_tag       = out_q.tag;

  always_ff @(posedge pcie_clk) begin
    if (wr)
      mem[wr_ptr] <= in_entry;
    if (rd)
      out_q <= mem[rd_ptr];
    else if (load && in_valid)
      out_q <= in_entry;
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + (PTR_W+1)'(wr) - (PTR_W+1)'(rd);
      if (load)
        out_valid <= (count != '0) || in_valid;
    end
  end

  a_no_write_when_full: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    wr |-> count != (PTR_W+1)'(`CW_SLOT_COUNT));

endmodule

/* src/frame_sink.sv */
// First beat must hold the PCIe address; a payload longer than one slot is not supported
`timescale 1ns/1ps
`include "cont_write_macros.svh"

module frame_sink
  import host_core_pkg::*, pcie_dma_pkg::*;
(
  input  logic                  pcie_clk,
  input  logic                  pcie_rst,

  input  logic [`CW_DATA_W-1:0] core_tx_data,
  input  logic [`CW_KEEP_W-1:0] core_tx_keep,
  input  core_user_t            core_tx_user,
  input  logic                  core_tx_valid,
  input  logic                  core_tx_last,
  output logic                  core_tx_ready,

  input  logic                  slot_valid,
  input  slot_t                 slot_id,
  output logic                  slot_ready,

  output logic                  hdr_valid,
  output pcie_addr_t            hdr_addr,
  output slot_t                 hdr_slot,

  output logic                  done_valid,
  output slot_t                 done_slot,
  output dma_len_t              done_len,
  output core_user_t            done_user,

  output logic                  ram_wr_en,
  output ram_word_t             ram_wr_addr,
  output logic [`CW_DATA_W-1:0] ram_wr_data,
  output logic [`CW_KEEP_W-1:0] ram_wr_be
);

  sink_state_e                       state;
  slot_t                             cur_slot;
  logic [`CW_SLOT_BYTES_LOG2-4:0]    word_cnt;
  dma_len_t                          byte_cnt;
  logic                              beat;

  function automatic dma_len_t keep_bytes(input logic [`CW_KEEP_W-1:0] keep);
    dma_len_t n;
    n = '0;
    for (int i = 0; i < `CW_KEEP_W; i++)
      n = n + dma_len_t'(keep[i]);
    return n;
  endfunction

  assign slot_ready    = (state == SINK_IDLE);
  assign core_tx_ready = (state == SINK_HEADER) || (state == SINK_DATA);
  assign beat          = core_tx_valid && core_tx_ready;

  assign hdr_valid = beat && (state == SINK_HEADER);
  assign hdr_addr  = core_tx_data;
  assign hdr_slot  = cur_slot;

  // Payload words fill the slot from its base
  assign ram_wr_en   = beat && (state == SINK_DATA);
  assign ram_wr_addr = {cur_slot, word_cnt};
  assign ram_wr_data = core_tx_data;
  assign ram_wr_be   = core_tx_keep;

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      state      <= SINK_IDLE;
      done_valid <= 1'b0;
    end else begin
      done_valid <= beat && core_tx_last;
      case (state)
        SINK_IDLE:   if (slot_valid) state <= SINK_HEADER;
        SINK_HEADER: if (beat) state <= core_tx_last ? SINK_IDLE : SINK_DATA;
        SINK_DATA:   if (beat && core_tx_last) state <= SINK_IDLE;
        default:     state <= SINK_IDLE;
      endcase
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (slot_valid && slot_ready) begin
      cur_slot <= slot_id;
      word_cnt <= '0;
      byte_cnt <= '0;
    end
    if (ram_wr_en) begin
      word_cnt <= word_cnt + 1'b1;
      byte_cnt <= byte_cnt + keep_bytes(core_tx_keep);
    end
    if (beat && core_tx_last) begin
      done_slot <= cur_slot;
      done_user <= core_tx_user;
      // Header-only frame carries no payload
      done_len  <= (state == SINK_DATA) ? byte_cnt + keep_bytes(core_tx_keep) : '0;
    end
  end

  // Bytes already written before this beat stay inside one slot
  a_frame_fits_slot: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    ram_wr_en |-> byte_cnt < dma_len_t'(`CW_SLOT_BYTES));

endmodule

/* src/host_core_pkg.sv */
// Host and core side types; the control word layout is what the cores expect on their ctrl port
`include "cont_write_macros.svh"

package host_core_pkg;

  typedef logic [`CW_HOST_TAG_W-1:0]      host_tag_t;
  typedef logic [`CW_CORE_ID_W-1:0]       core_id_t;
  typedef logic [`CW_HOST_RAM_ADDR_W-1:0] host_ram_addr_t;

  // Control word sent to a core, reserved fields are zero
  typedef struct packed {
    logic [`CW_PCIE_ADDR_W-1:0] pcie_addr;
    logic [15:0]                rsvd_hi;
    logic [`CW_CORE_ADDR_W-1:0] ram_addr;
    logic [15:0]                rsvd_lo;
    logic [`CW_LEN_W-1:0]       len;
  } ctrl_word_t;

  // Frame user field from the cores
  typedef struct packed {
    core_id_t                                 core_id;
    logic [`CW_USER_W-`CW_CORE_ID_W-1:0]      frame_tag;
  } core_user_t;

endpackage

/* src/host_request_tracker.sv */
// One outstanding host write per core; status returns only for completions with frame tag zero
`timescale 1ns/1ps
`include "cont_write_macros.svh"

module host_request_tracker
  import host_core_pkg::*, pcie_dma_pkg::*;
(
  input  logic           pcie_clk,
  input  logic           pcie_rst,

  input  pcie_addr_t     host_desc_pcie_addr,
  input  host_ram_addr_t host_desc_ram_addr,
  input  dma_len_t       host_desc_len,
  input  host_tag_t      host_desc_tag,
  input  logic           host_desc_valid,
  output logic           host_desc_ready,

  output ctrl_word_t     host_core_ctrl_data,
  output core_id_t       host_core_ctrl_dest,
  output logic           host_core_ctrl_valid,
  input  logic           host_core_ctrl_ready,

  input  logic           cmpl_valid,
  input  core_user_t     cmpl_user,

  output host_tag_t      host_status_tag,
  output logic           host_status_valid
);

  host_tag_t                 tag_tbl [`CW_CORE_COUNT];
  logic [`CW_CORE_COUNT-1:0] busy;
  core_id_t                  dest;
  logic                      accept;
  logic                      ret;

  // Target core sits right above the core-local address bits
  assign dest            = host_desc_ram_addr[`CW_CORE_ADDR_W +: `CW_CORE_ID_W];
  assign host_desc_ready = host_core_ctrl_ready && !busy[dest];
  assign accept          = host_desc_valid && host_desc_ready;
  assign ret             = cmpl_valid && (cmpl_user.frame_tag == '0);

  always_ff @(posedge pcie_clk) begin
    if (accept) begin
      host_core_ctrl_data <= '{pcie_addr: host_desc_pcie_addr,
                               ram_addr:  host_desc_ram_addr[`CW_CORE_ADDR_W-1:0],
                               len:       host_desc_len,
                               default:   '0};
      host_core_ctrl_dest <= dest;
      tag_tbl[dest]       <= host_desc_tag;
    end
    if (ret)
      host_status_tag <= tag_tbl[cmpl_user.core_id];
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      busy                 <= '0;
      host_core_ctrl_valid <= 1'b0;
      host_status_valid    <= 1'b0;
    end else begin
      host_core_ctrl_valid <= accept;
      host_status_valid    <= ret && busy[cmpl_user.core_id];
      if (ret)
        busy[cmpl_user.core_id] <= 1'b0;
      // New request can reuse a core freed in the same cycle
      if (accept)
        busy[dest] <= 1'b1;
    end
  end

  // Frame tag zero completion must belong to a core that holds a host tag
  a_ret_core_busy: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    ret |-> busy[cmpl_user.core_id]);

endmodule

/* src/pcie_cont_write.sv */
// Host write engine top; core control has no hold, so cores must take it when ready is high
`timescale 1ns/1ps
`include "cont_write_macros.svh"

module pcie_cont_write
  import host_core_pkg::*, pcie_dma_pkg::*;
(
  input  logic                  pcie_clk,
  input  logic                  pcie_rst,

  input  pcie_addr_t            host_desc_pcie_addr,
  input  host_ram_addr_t        host_desc_ram_addr,
  input  dma_len_t              host_desc_len,
  input  host_tag_t             host_desc_tag,
  input  logic                  host_desc_valid,
  output logic                  host_desc_ready,

  output ctrl_word_t            host_core_ctrl_data,
  output core_id_t              host_core_ctrl_dest,
  output logic                  host_core_ctrl_valid,
  input  logic                  host_core_ctrl_ready,

  output host_tag_t             host_status_tag,
  output logic                  host_status_valid,

  input  logic [`CW_DATA_W-1:0] core_tx_data,
  input  logic [`CW_KEEP_W-1:0] core_tx_keep,
  input  core_user_t            core_tx_user,
  input  logic                  core_tx_valid,
  input  logic                  core_tx_last,
  output logic                  core_tx_ready,

  output pcie_addr_t            pcie_desc_pcie_addr,
  output ram_addr_t             pcie_desc_ram_addr,
  output dma_len_t              pcie_desc_len,
  output slot_t                 pcie_desc_tag,
  output logic                  pcie_desc_valid,
  input  logic                  pcie_desc_ready,

  input  slot_t                 pcie_status_tag,
  input  logic                  pcie_status_valid,

  input  ram_word_t             ram_rd_addr,
  input  logic                  ram_rd_en,
  output logic [`CW_DATA_W-1:0] ram_rd_data,
  output logic                  ram_rd_data_valid
);

  logic                  slot_valid;
  slot_t                 slot_id;
  logic                  slot_ready;
  logic                  hdr_valid;
  pcie_addr_t            hdr_addr;
  slot_t                 hdr_slot;
  logic                  done_valid;
  slot_t                 done_slot;
  dma_len_t              done_len;
  core_user_t            done_user;
  logic                  cmpl_valid;
  core_user_t            cmpl_user;
  logic                  ram_wr_en;
  ram_word_t             ram_wr_addr;
  logic [`CW_DATA_W-1:0] ram_wr_data;
  logic [`CW_KEEP_W-1:0] ram_wr_be;

  host_request_tracker host_request_tracker_inst (
    .pcie_clk, .pcie_rst,
    .host_desc_pcie_addr, .host_desc_ram_addr, .host_desc_len, .host_desc_tag,
    .host_desc_valid, .host_desc_ready,
    .host_core_ctrl_data, .host_core_ctrl_dest, .host_core_ctrl_valid,
    .host_core_ctrl_ready,
    .cmpl_valid, .cmpl_user,
    .host_status_tag, .host_status_valid
  );

  frame_sink frame_sink_inst (
    .pcie_clk, .pcie_rst,
    .core_tx_data, .core_tx_keep, .core_tx_user, .core_tx_valid, .core_tx_last,
    .core_tx_ready,
    .slot_valid, .slot_id, .slot_ready,
    .hdr_valid, .hdr_addr, .hdr_slot,
    .done_valid, .done_slot, .done_len, .done_user,
    .ram_wr_en, .ram_wr_addr, .ram_wr_data, .ram_wr_be
  );

  tx_slot_manager tx_slot_manager_inst (
    .pcie_clk, .pcie_rst,
    .slot_valid, .slot_id, .slot_ready,
    .hdr_valid, .hdr_addr, .hdr_slot,
    .done_valid, .done_slot, .done_len, .done_user,
    .pcie_desc_pcie_addr, .pcie_desc_ram_addr, .pcie_desc_len, .pcie_desc_tag,
    .pcie_desc_valid, .pcie_desc_ready,
    .pcie_status_tag, .pcie_status_valid,
    .cmpl_valid, .cmpl_user
  );

  // DMA reads the slot payload here
  scratchpad_ram scratchpad_ram_inst (
    .pcie_clk     (pcie_clk),
    .wr_en        (ram_wr_en),
    .wr_addr      (ram_wr_addr),
    .wr_data      (ram_wr_data),
    .wr_be        (ram_wr_be),
    .rd_en        (ram_rd_en),
    .rd_addr      (ram_rd_addr),
    .rd_data      (ram_rd_data),
    .rd_data_valid(ram_rd_data_valid)
  );

endmodule

/* src/pcie_dma_pkg.sv */
// PCIe DMA side types; RAM addresses are byte addresses, RAM words are 64 bits
`include "cont_write_macros.svh"

package pcie_dma_pkg;

  typedef logic [`CW_SLOT_W-1:0]      slot_t;
  typedef logic [`CW_PCIE_ADDR_W-1:0] pcie_addr_t;
  typedef logic [`CW_RAM_ADDR_W-1:0]  ram_addr_t;
  typedef logic [`CW_RAM_WORD_W-1:0]  ram_word_t;
  typedef logic [`CW_LEN_W-1:0]       dma_len_t;

  // Frame sink FSM
  typedef enum logic [1:0] {
    SINK_IDLE,
    SINK_HEADER,
    SINK_DATA
  } sink_state_e;

endpackage

/* src/scratchpad_ram.sv */
// Read data is undefined for words never written; read and write to one word in a cycle reads old data
`timescale 1ns/1ps
`include "cont_write_macros.svh"

module scratchpad_ram
  import pcie_dma_pkg::*;
(
  input  logic                  pcie_clk,

  input  logic                  wr_en,
  input  ram_word_t             wr_addr,
  input  logic [`CW_DATA_W-1:0] wr_data,
  input  logic [`CW_KEEP_W-1:0] wr_be,

  input  logic                  rd_en,
  input  ram_word_t             rd_addr,
  output logic [`CW_DATA_W-1:0] rd_data,
  output logic                  rd_data_valid
);

  logic [`CW_DATA_W-1:0] mem [2**`CW_RAM_WORD_W];

  always_ff @(posedge pcie_clk) begin
    // Byte lane writes
    for (int i = 0; i < `CW_KEEP_W; i++)
      if (wr_en && wr_be[i])
        mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
    if (rd_en)
      rd_data <= mem[rd_addr];
    rd_data_valid <= rd_en;
  end

endmodule

/* src/tx_slot_manager.sv */
// Slots are granted lowest-free-first; the DMA must complete only slots it was given descriptors for
`timescale 1ns/1ps
`include "cont_write_macros.svh"

module tx_slot_manager
  import host_core_pkg::*, pcie_dma_pkg::*;
(
  input  logic       pcie_clk,
  input  logic       pcie_rst,

  output logic       slot_valid,
  output slot_t      slot_id,
  input  logic       slot_ready,

  input  logic       hdr_valid,
  input  pcie_addr_t hdr_addr,
  input  slot_t      hdr_slot,

  input  logic       done_valid,
  input  slot_t      done_slot,
  input  dma_len_t   done_len,
  input  core_user_t done_user,

  output pcie_addr_t pcie_desc_pcie_addr,
  output ram_addr_t  pcie_desc_ram_addr,
  output dma_len_t   pcie_desc_len,
  output slot_t      pcie_desc_tag,
  output logic       pcie_desc_valid,
  input  logic       pcie_desc_ready,

  input  slot_t      pcie_status_tag,
  input  logic       pcie_status_valid,

  output logic       cmpl_valid,
  output core_user_t cmpl_user
);

  logic [`CW_SLOT_COUNT-1:0] free_q;
  pcie_addr_t                addr_tbl [`CW_SLOT_COUNT];
  core_user_t                user_tbl [`CW_SLOT_COUNT];
  slot_t                     low_free;
  logic                      take;

  logic       d_valid;
  pcie_addr_t d_addr;
  ram_addr_t  d_ram;
  dma_len_t   d_len;
  slot_t      d_tag;

  // Priority pick of the lowest free slot
  always_comb begin
    low_free = '0;
    for (int i = `CW_SLOT_COUNT - 1; i >= 0; i--)
      if (free_q[i])
        low_free = slot_t'(i);
  end

  assign slot_valid = |free_q;
  assign slot_id    = low_free;
  assign take       = slot_valid && slot_ready;

  always_ff @(posedge pcie_clk) begin
    if (hdr_valid)
      addr_tbl[hdr_slot] <= hdr_addr;
    if (done_valid) begin
      user_tbl[done_slot] <= done_user;
      d_addr              <= addr_tbl[done_slot];
      d_ram               <= {done_slot, {`CW_SLOT_BYTES_LOG2{1'b0}}};
      d_len               <= done_len;
      d_tag               <= done_slot;
    end
    cmpl_user <= user_tbl[pcie_status_tag];
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      free_q     <= '1;
      d_valid    <= 1'b0;
      cmpl_valid <= 1'b0;
    end else begin
      d_valid    <= done_valid;
      cmpl_valid <= pcie_status_valid;
      free_q     <= (free_q & ~({{(`CW_SLOT_COUNT-1){1'b0}}, take} << slot_id))
                  | ({{(`CW_SLOT_COUNT-1){1'b0}}, pcie_status_valid} << pcie_status_tag);
    end
  end

  // FIFO holds one entry per slot so it needs no ready
  desc_fifo desc_fifo_inst (
    .pcie_clk     (pcie_clk),
    .pcie_rst     (pcie_rst),
    .in_valid     (d_valid),
    .in_pcie_addr (d_addr),
    .in_ram_addr  (d_ram),
    .in_len       (d_len),
    .in_tag       (d_tag),
    .out_valid    (pcie_desc_valid),
    .out_pcie_addr(pcie_desc_pcie_addr),
    .out_ram_addr (pcie_desc_ram_addr),
    .out_len      (pcie_desc_len),
    .out_tag      (pcie_desc_tag),
    .out_ready    (pcie_desc_ready)
  );

  // Completion must name a slot granted earlier and not yet freed
  a_cmpl_slot_in_use: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    pcie_status_valid |-> !free_q[pcie_status_tag]);

endmodule

/* tb.f */
+incdir+src
src/host_core_pkg.sv
src/pcie_dma_pkg.sv
src/desc_fifo.sv
src/scratchpad_ram.sv
src/host_request_tracker.sv
src/frame_sink.sv
src/tx_slot_manager.sv
src/pcie_cont_write.sv
dv/tb_pcie_cont_write.sv
